//--- hdl/dpram_sub_pkg.sv
// shared widths, depths, word types and the request op for the dual-port subtracting memory
`default_nettype none

package dpram_sub_pkg;

    // memory geometry
    localparam int data_w = 8;                   // word width
    localparam int addr_w = 6;                   // 64 words

    // flow control
    localparam int req_depth = 4;                // queue entries, also host credits after reset
    localparam int res_credits = 4;              // result credits held by the DUT after reset
    localparam int cnt_w = 3;                    // holds 0 to 4
    localparam int ptr_w = $clog2(req_depth);    // queue pointer width

    // subtractor blocking
    localparam int sub_blk_w = 4;                // bits per conditional-sum block
    localparam int sub_blk_n = data_w / sub_blk_w; // number of blocks in a word

    typedef logic [data_w-1:0] data_t;           // words, operands, differences
    typedef logic [addr_w-1:0] addr_t;           // memory addresses
    typedef logic [cnt_w-1:0] cnt_t;             // fill levels and credit counts
    typedef logic [ptr_w-1:0] ptr_t;             // queue read and write pointers

    // what a request does besides reading
    typedef enum logic {
        op_read  = 1'b0,                         // read and subtract only
        op_write = 1'b1                          // store the operand as well
    } req_op_e;

endpackage

`default_nettype wire

//--- hdl/req_fifo.sv
// per-port request queue, filled by the host under credit control and drained by the scheduler
`default_nettype none

module req_fifo
    import dpram_sub_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  req_op_e push_op,
    input  addr_t   push_addr,
    input  data_t   push_data,
    input  logic    pop,
    output logic    not_empty,
    output req_op_e head_op,
    output addr_t   head_addr,
    output data_t   head_data
);

    req_op_e op_mem [req_depth];                 // entry storage
    addr_t   addr_mem [req_depth];
    data_t   data_mem [req_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t fill;                                  // entries currently held

    // host credits keep push away from a full queue
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= push_op;
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;         // wraps at req_depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;           // both or neither
            endcase
        end
    end

    assign not_empty = (fill != '0);
    assign head_op   = op_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/port_scheduler.sv
// issue control for both ports: tracks result credits, pops queue heads and returns request credits
`default_nettype none

module port_scheduler
    import dpram_sub_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic not_empty_a,
    input  logic not_empty_b,
    input  logic res_credit_a,
    input  logic res_credit_b,
    output logic pop_a,
    output logic pop_b,
    output logic req_credit_a,
    output logic req_credit_b
);

    cnt_t res_cnt_a;                             // result slots the consumer still has free
    cnt_t res_cnt_b;

    // the ports issue independently, no arbitration between them
    assign pop_a = not_empty_a && (res_cnt_a != '0);
    assign pop_b = not_empty_b && (res_cnt_b != '0);

    // port a result credits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_cnt_a <= cnt_t'(res_credits);
        end else begin
            case ({pop_a, res_credit_a})
                2'b10:   res_cnt_a <= res_cnt_a - 1'b1; // spent on issue
                2'b01:   res_cnt_a <= res_cnt_a + 1'b1; // consumer freed a slot
                default: res_cnt_a <= res_cnt_a;
            endcase
        end
    end

    // port b result credits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_cnt_b <= cnt_t'(res_credits);
        end else begin
            case ({pop_b, res_credit_b})
                2'b10:   res_cnt_b <= res_cnt_b - 1'b1;
                2'b01:   res_cnt_b <= res_cnt_b + 1'b1;
                default: res_cnt_b <= res_cnt_b;
            endcase
        end
    end

    // a popped entry frees one queue slot, handed back to the host next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_credit_a <= 1'b0;
            req_credit_b <= 1'b0;
        end else begin
            req_credit_a <= pop_a;
            req_credit_b <= pop_b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dp_ram_core.sv
// two-port word memory with input registers and a read-before-write stage; valid bits follow the data
`default_nettype none

module dp_ram_core
    import dpram_sub_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    iss_valid_a,
    input  logic    iss_valid_b,
    input  req_op_e iss_op_a,
    input  req_op_e iss_op_b,
    input  addr_t   iss_addr_a,
    input  addr_t   iss_addr_b,
    input  data_t   iss_data_a,
    input  data_t   iss_data_b,
    output logic    rd_valid_a,
    output logic    rd_valid_b,
    output data_t   rd_data_a,
    output data_t   rd_data_b,
    output data_t   opnd_a,
    output data_t   opnd_b
);

    data_t ram [2**addr_w];                      // word array, no init

    logic    valid_a_reg, valid_b_reg;           // slot occupied
    req_op_e op_a_reg, op_b_reg;
    addr_t   addr_a_reg, addr_b_reg;
    data_t   data_a_reg, data_b_reg;

    // input register stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_a_reg <= 1'b0;
            valid_b_reg <= 1'b0;
        end else begin
            valid_a_reg <= iss_valid_a;
            valid_b_reg <= iss_valid_b;
        end
    end

    always_ff @(posedge clk) begin
        op_a_reg   <= iss_op_a;
        op_b_reg   <= iss_op_b;
        addr_a_reg <= iss_addr_a;
        addr_b_reg <= iss_addr_b;
        data_a_reg <= iss_data_a;
        data_b_reg <= iss_data_b;
    end

    // memory stage, b is written last so it wins on a shared address
    always_ff @(posedge clk) begin
        if (valid_a_reg && op_a_reg == op_write)
            ram[addr_a_reg] <= data_a_reg;
        if (valid_b_reg && op_b_reg == op_write)
            ram[addr_b_reg] <= data_b_reg;
        opnd_a <= data_a_reg;                    // lines up with rd_data
        opnd_b <= data_b_reg;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid_a <= 1'b0;
            rd_valid_b <= 1'b0;
            rd_data_a  <= '0;
            rd_data_b  <= '0;
        end else begin
            rd_valid_a <= valid_a_reg;           // bubbles pass through as zero
            rd_valid_b <= valid_b_reg;
            rd_data_a  <= ram[addr_a_reg];       // old word, before this edge's writes
            rd_data_b  <= ram[addr_b_reg];
        end
    end

endmodule

`default_nettype wire

//--- hdl/cond_sum_subtractor.sv
// conditional-sum subtractor giving minuend minus subtrahend and the final borrow, purely combinational
`default_nettype none

module cond_sum_subtractor
    import dpram_sub_pkg::*;
(
    input  data_t minuend,
    input  data_t subtrahend,
    output data_t diff,
    output logic  borrow
);

    logic [sub_blk_n:0] blk_borrow;              // borrow entering each block

    assign blk_borrow[0] = 1'b0;

    for (genvar i = 0; i < sub_blk_n; i++) begin : g_blk
        logic [sub_blk_w-1:0] a_blk;
        logic [sub_blk_w-1:0] b_blk;
        logic [sub_blk_w:0]   res0;              // assumes no borrow in
        logic [sub_blk_w:0]   res1;              // assumes borrow in

        assign a_blk = minuend[i*sub_blk_w +: sub_blk_w];
        assign b_blk = subtrahend[i*sub_blk_w +: sub_blk_w];

        // top bit of each result is the block's borrow out
        assign res0 = {1'b0, a_blk} - {1'b0, b_blk};
        assign res1 = {1'b0, a_blk} - {1'b0, b_blk} - 1'b1;

        // incoming borrow picks one of the precomputed results
        assign diff[i*sub_blk_w +: sub_blk_w] = blk_borrow[i] ? res1[sub_blk_w-1:0]
                                                              : res0[sub_blk_w-1:0];
        assign blk_borrow[i+1] = blk_borrow[i] ? res1[sub_blk_w] : res0[sub_blk_w];
    end

    assign borrow = blk_borrow[sub_blk_n];      // set when minuend < subtrahend

endmodule

`default_nettype wire

//--- hdl/dpram_sub_top.sv
// top of the dual-port read-and-subtract memory with credit flow control on requests and results
`default_nettype none

module dpram_sub_top
    import dpram_sub_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid_a,
    input  req_op_e req_op_a,
    input  addr_t   req_addr_a,
    input  data_t   req_data_a,
    output logic    req_credit_a,
    output logic    res_valid_a,
    output data_t   res_dout_a,
    output data_t   res_diff_a,
    output logic    res_borrow_a,
    input  logic    res_credit_a,
    input  logic    req_valid_b,
    input  req_op_e req_op_b,
    input  addr_t   req_addr_b,
    input  data_t   req_data_b,
    output logic    req_credit_b,
    output logic    res_valid_b,
    output data_t   res_dout_b,
    output data_t   res_diff_b,
    output logic    res_borrow_b,
    input  logic    res_credit_b
);

    logic    not_empty_a, not_empty_b;
    req_op_e head_op_a, head_op_b;
    addr_t   head_addr_a, head_addr_b;
    data_t   head_data_a, head_data_b;
    logic    pop_a, pop_b;                       // also the core's issue valids
    data_t   opnd_a, opnd_b;

    req_fifo u_fifo_a (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid_a),
        .push_op   (req_op_a),
        .push_addr (req_addr_a),
        .push_data (req_data_a),
        .pop       (pop_a),
        .not_empty (not_empty_a),
        .head_op   (head_op_a),
        .head_addr (head_addr_a),
        .head_data (head_data_a)
    );

    req_fifo u_fifo_b (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid_b),
        .push_op   (req_op_b),
        .push_addr (req_addr_b),
        .push_data (req_data_b),
        .pop       (pop_b),
        .not_empty (not_empty_b),
        .head_op   (head_op_b),
        .head_addr (head_addr_b),
        .head_data (head_data_b)
    );

    port_scheduler u_sched (
        .clk          (clk),
        .rst          (rst),
        .not_empty_a  (not_empty_a),
        .not_empty_b  (not_empty_b),
        .res_credit_a (res_credit_a),
        .res_credit_b (res_credit_b),
        .pop_a        (pop_a),
        .pop_b        (pop_b),
        .req_credit_a (req_credit_a),
        .req_credit_b (req_credit_b)
    );

    // queue heads go straight into the core's input registers on issue
    dp_ram_core u_core (
        .clk         (clk),
        .rst         (rst),
        .iss_valid_a (pop_a),
        .iss_valid_b (pop_b),
        .iss_op_a    (head_op_a),
        .iss_op_b    (head_op_b),
        .iss_addr_a  (head_addr_a),
        .iss_addr_b  (head_addr_b),
        .iss_data_a  (head_data_a),
        .iss_data_b  (head_data_b),
        .rd_valid_a  (res_valid_a),
        .rd_valid_b  (res_valid_b),
        .rd_data_a   (res_dout_a),
        .rd_data_b   (res_dout_b),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b)
    );

    cond_sum_subtractor u_sub_a (
        .minuend    (res_dout_a),
        .subtrahend (opnd_a),
        .diff       (res_diff_a),
        .borrow     (res_borrow_a)
    );

    cond_sum_subtractor u_sub_b (
        .minuend    (res_dout_b),
        .subtrahend (opnd_b),
        .diff       (res_diff_b),
        .borrow     (res_borrow_b)
    );

endmodule

`default_nettype wire

//--- tests/result_checker.sv
// result checker that compares results with the per-port expected queues and tracks both credit flows
`default_nettype none

module result_checker
    import dpram_sub_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  req_valid_a,
    input logic  req_credit_a,
    input logic  res_valid_a,
    input data_t res_dout_a,
    input data_t res_diff_a,
    input logic  res_borrow_a,
    input logic  res_credit_a,
    input logic  req_valid_b,
    input logic  req_credit_b,
    input logic  res_valid_b,
    input data_t res_dout_b,
    input data_t res_diff_b,
    input logic  res_borrow_b,
    input logic  res_credit_b
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [2*data_w+1:0] exp_a [$];              // {chk, old, diff, borrow}
    logic [2*data_w+1:0] exp_b [$];
    int held_a = 0;                              // delivered but not yet credited
    int held_b = 0;
    int queued_a = 0;                            // pushed and waiting for its request credit
    int queued_b = 0;
    int value_errors = 0;
    int protocol_errors = 0;

    task automatic add_expected(input logic port, input logic chk, input data_t old_word,
                                input data_t diff, input logic borrow);
        if (port)
            exp_b.push_back({chk, old_word, diff, borrow});
        else
            exp_a.push_back({chk, old_word, diff, borrow});
    endtask

    function automatic int pending();
        return exp_a.size() + exp_b.size();
    endfunction

    task automatic compare_field(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_result(input logic port, input data_t dout, input data_t diff,
                                input logic borrow);
        logic [2*data_w+1:0] exp;
        string p;
        p = port ? "b" : "a";
        if ((port ? exp_b.size() : exp_a.size()) == 0) begin
            $display("port %s returned a result at %0d ns with nothing outstanding", p, $time);
            protocol_errors++;
        end else begin
            if (port)
                exp = exp_b.pop_front();
            else
                exp = exp_a.pop_front();
            // chk is low on a first write whose old word is unknown
            if (exp[2*data_w+1]) begin
                compare_field({"res_dout_", p}, exp[2*data_w:data_w+1], dout);
                compare_field({"res_diff_", p}, exp[data_w:1], diff);
                compare_field({"res_borrow_", p}, data_t'(exp[0]), data_t'(borrow));
            end
        end
    endtask

    task automatic report_leftovers();
        if (exp_a.size() != 0) begin
            $display("port a still owes %0d results at the end of the run", exp_a.size());
            protocol_errors++;
        end
        if (exp_b.size() != 0) begin
            $display("port b still owes %0d results at the end of the run", exp_b.size());
            protocol_errors++;
        end
        if (queued_a != 0) begin
            $display("port a never returned %0d request credits", queued_a);
            protocol_errors++;
        end
        if (queued_b != 0) begin
            $display("port b never returned %0d request credits", queued_b);
            protocol_errors++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (res_valid_a)
                check_result(1'b0, res_dout_a, res_diff_a, res_borrow_a);
            if (res_valid_b)
                check_result(1'b1, res_dout_b, res_diff_b, res_borrow_b);
            held_a = held_a + (res_valid_a ? 1 : 0) - (res_credit_a ? 1 : 0);
            held_b = held_b + (res_valid_b ? 1 : 0) - (res_credit_b ? 1 : 0);
            if (held_a > res_credits) begin
                $display("port a sent a result at %0d ns with no result credit left", $time);
                protocol_errors++;
            end
            if (held_b > res_credits) begin
                $display("port b sent a result at %0d ns with no result credit left", $time);
                protocol_errors++;
            end
            queued_a = queued_a + (req_valid_a ? 1 : 0) - (req_credit_a ? 1 : 0);
            queued_b = queued_b + (req_valid_b ? 1 : 0) - (req_credit_b ? 1 : 0);
            if (queued_a < 0) begin
                $display("port a returned an extra request credit at %0d ns", $time);
                protocol_errors++;
                queued_a = 0;
            end
            if (queued_b < 0) begin
                $display("port b returned an extra request credit at %0d ns", $time);
                protocol_errors++;
                queued_b = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_dpram_sub.sv
// testbench for the dual-port subtracting memory that runs the golden file through both ports
`default_nettype none

module tb_dpram_sub
    import dpram_sub_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int gold_fields = 8;              // port op addr operand chk old diff borrow
    localparam int gold_max = 64;                // lines including the end marker
    localparam int idle_limit = 200;             // cycles without a request credit
    localparam int drain_limit = 1000;           // cycles for the last results

    logic    clk;
    logic    rst;
    logic    req_valid_a, req_valid_b;
    req_op_e req_op_a, req_op_b;
    addr_t   req_addr_a, req_addr_b;
    data_t   req_data_a, req_data_b;
    logic    req_credit_a, req_credit_b;
    logic    res_valid_a, res_valid_b;
    data_t   res_dout_a, res_dout_b;
    data_t   res_diff_a, res_diff_b;
    logic    res_borrow_a, res_borrow_b;
    logic    res_credit_a, res_credit_b;

    logic [7:0] golden [gold_fields*gold_max];
    logic [addr_w+data_w:0] stim_a [$];          // {op, addr, operand}
    logic [addr_w+data_w:0] stim_b [$];
    logic [31:0] lfsr;
    int held_a, held_b;                          // results used but not yet credited
    int timeouts;
    int file_errors;

    dpram_sub_top u_dpram_sub_top (
        .clk          (clk),
        .rst          (rst),
        .req_valid_a  (req_valid_a),
        .req_op_a     (req_op_a),
        .req_addr_a   (req_addr_a),
        .req_data_a   (req_data_a),
        .req_credit_a (req_credit_a),
        .res_valid_a  (res_valid_a),
        .res_dout_a   (res_dout_a),
        .res_diff_a   (res_diff_a),
        .res_borrow_a (res_borrow_a),
        .res_credit_a (res_credit_a),
        .req_valid_b  (req_valid_b),
        .req_op_b     (req_op_b),
        .req_addr_b   (req_addr_b),
        .req_data_b   (req_data_b),
        .req_credit_b (req_credit_b),
        .res_valid_b  (res_valid_b),
        .res_dout_b   (res_dout_b),
        .res_diff_b   (res_diff_b),
        .res_borrow_b (res_borrow_b),
        .res_credit_b (res_credit_b)
    );

    result_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .req_valid_a  (req_valid_a),
        .req_credit_a (req_credit_a),
        .res_valid_a  (res_valid_a),
        .res_dout_a   (res_dout_a),
        .res_diff_a   (res_diff_a),
        .res_borrow_a (res_borrow_a),
        .res_credit_a (res_credit_a),
        .req_valid_b  (req_valid_b),
        .req_credit_b (req_credit_b),
        .res_valid_b  (res_valid_b),
        .res_dout_b   (res_dout_b),
        .res_diff_b   (res_diff_b),
        .res_borrow_b (res_borrow_b),
        .res_credit_b (res_credit_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                   // 4 ns period
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic load_golden();
        int  i;
        int  base;
        logic bad;
        i = 0;
        bad = 1'b0;
        $readmemh("tests/dpram_sub_golden.txt", golden);
        while (i < gold_max && golden[i*gold_fields] !== 8'hff && !bad) begin
            base = i * gold_fields;
            if ($isunknown(golden[base])) begin
                $display("golden file line %0d could not be read", i);
                file_errors++;
                bad = 1'b1;
            end else begin
                if (golden[base] == 8'h00)
                    stim_a.push_back({golden[base+1][0], golden[base+2][addr_w-1:0],
                                      golden[base+3]});
                else
                    stim_b.push_back({golden[base+1][0], golden[base+2][addr_w-1:0],
                                      golden[base+3]});
                u_checker.add_expected(golden[base] != 8'h00, golden[base+4][0], golden[base+5],
                                       golden[base+6], golden[base+7][0]);
                i++;
            end
        end
        if (i == gold_max || i == 0) begin
            $display("golden file has no requests or no end marker");
            file_errors++;
        end
    endtask

    task automatic put_request(input int port, input logic valid,
                               input logic [addr_w+data_w:0] req);
        if (port == 0) begin
            req_valid_a = valid;
            req_op_a    = req_op_e'(req[addr_w+data_w]);
            req_addr_a  = req[data_w +: addr_w];
            req_data_a  = req[data_w-1:0];
        end else begin
            req_valid_b = valid;
            req_op_b    = req_op_e'(req[addr_w+data_w]);
            req_addr_b  = req[data_w +: addr_w];
            req_data_b  = req[data_w-1:0];
        end
    endtask

    task automatic send_requests(input int port);
        int    credits;
        int    idle;
        string pname;
        logic [addr_w+data_w:0] req;
        credits = req_depth;                     // host starts with a full queue's worth
        idle = 0;
        pname = (port == 0) ? "a" : "b";
        while ((port == 0 ? stim_a.size() : stim_b.size()) > 0 && idle < idle_limit) begin
            @(posedge clk);
            #1;
            if (port == 0 ? req_credit_a : req_credit_b)
                credits++;
            if (credits > 0) begin
                if (port == 0)
                    req = stim_a.pop_front();
                else
                    req = stim_b.pop_front();
                put_request(port, 1'b1, req);
                credits--;
                idle = 0;
            end else begin
                put_request(port, 1'b0, '0);
                idle++;
            end
        end
        if (idle >= idle_limit) begin
            $display("timeout: port %s got no request credit back for %0d cycles", pname, idle);
            timeouts++;
        end
        @(posedge clk);
        #1;
        put_request(port, 1'b0, '0);
    endtask

    // consumer hands result credits back at a random pace
    initial begin
        lfsr = 32'd97243;
        held_a = 0;
        held_b = 0;
        forever begin
            @(posedge clk);
            #1;
            res_credit_a = 1'b0;
            res_credit_b = 1'b0;
            if (held_a > 0) begin
                res_credit_a = lfsr[0];
                if (lfsr[0])
                    held_a--;
                lfsr = lfsr_next(lfsr);
            end
            if (held_b > 0) begin
                res_credit_b = lfsr[0];
                if (lfsr[0])
                    held_b--;
                lfsr = lfsr_next(lfsr);
            end
            if (res_valid_a)
                held_a++;                        // credited no earlier than next cycle
            if (res_valid_b)
                held_b++;
        end
    end

    initial begin
        int waited;
        rst = 1'b1;
        req_valid_a = 1'b0;
        req_valid_b = 1'b0;
        req_op_a = op_read;
        req_op_b = op_read;
        req_addr_a = '0;
        req_addr_b = '0;
        req_data_a = '0;
        req_data_b = '0;
        res_credit_a = 1'b0;
        res_credit_b = 1'b0;
        timeouts = 0;
        file_errors = 0;
        load_golden();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // both ports start together so their first writes meet in the memory
        fork
            send_requests(0);
            send_requests(1);
        join
        waited = 0;
        while (u_checker.pending() > 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= drain_limit) begin
            $display("timeout: results still missing after %0d cycles", drain_limit);
            timeouts++;
        end
        repeat (8) @(posedge clk);               // room for stray results
        u_checker.report_leftovers();
        $display("errors: value %0d, protocol %0d, timeout %0d, golden file %0d",
                 u_checker.value_errors, u_checker.protocol_errors, timeouts, file_errors);
        if (u_checker.value_errors + u_checker.protocol_errors + timeouts + file_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/dpram_sub_golden.txt
// port (0 a, 1 b), op (1 write), addr, operand, chk, old word, diff, borrow
// chk 0 marks a first write whose old word is unknown, a port of ff ends the list
0 1 3f a5 0 00 00 0
0 1 00 10 0 00 00 0
0 1 01 80 0 00 00 0
0 1 02 00 0 00 00 0
0 0 00 01 1 10 0f 0
0 0 01 80 1 80 00 0
0 0 02 ff 1 00 01 1
0 1 00 33 1 10 dd 1
0 0 00 33 1 33 00 0
0 0 3f 5b 1 5b 00 0
0 1 01 7c 1 80 04 0
0 0 01 7d 1 7c ff 1
1 1 3f 5b 0 00 00 0
1 1 20 c3 0 00 00 0
1 1 21 0f 0 00 00 0
1 0 20 3c 1 c3 87 0
1 0 21 10 1 0f ff 1
1 1 21 f0 1 0f 1f 1
1 0 21 0f 1 f0 e1 0
1 0 3f a5 1 5b b6 1
1 1 22 fe 0 00 00 0
1 0 22 fe 1 fe 00 0
1 1 20 01 1 c3 c2 0
1 0 20 02 1 01 ff 1
ff 0 00 00 0 00 00 0

//--- all.f
hdl/dpram_sub_pkg.sv
hdl/req_fifo.sv
hdl/port_scheduler.sv
hdl/dp_ram_core.sv
hdl/cond_sum_subtractor.sv
hdl/dpram_sub_top.sv
tests/result_checker.sv
tests/tb_dpram_sub.sv

//--- Bender.yml
package:
  name: dpram_sub

sources:
  - hdl/dpram_sub_pkg.sv
  - hdl/req_fifo.sv
  - hdl/port_scheduler.sv
  - hdl/dp_ram_core.sv
  - hdl/cond_sum_subtractor.sv
  - hdl/dpram_sub_top.sv
  - target: test
    files:
      - tests/result_checker.sv
      - tests/tb_dpram_sub.sv
